// File: Makefile
# Verilator build for the LSPC raster timer testbench

VERILATOR ?= verilator
TOP       ?= tbLspcTimer
FILELIST  ?= all.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_TEXT ?= RESULT: PASS

BIN = $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Fails unless the pass line appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD)

// File: all.f
common/lspcPkg.sv
common/timerCtrlIf.sv
common/videoTimingIf.sv
rtl/lspcRegs.sv
rtl/videoCounter.sv
rtl/rasterTimer/rasterTimer.sv
rtl/lspcTimerTop.sv
tests/tbLspcTimer.sv

// File: common/lspcPkg.sv
//======================================================================
// LSPC raster timer shared definitions
// Video timing constants, CPU register map and the bit positions
// of the timer control word
//======================================================================

package lspcPkg;

	//======================================================================
	// Video timing
	//======================================================================

	// Pixel clocks (6 MHz) in one video line
	localparam int pixelsPerLine = 384;
	// Lines in one frame
	localparam int linesPerFrame = 264;
	// Pixel counter width
	localparam int pixelWidth = $clog2(pixelsPerLine);

	// Raster line number width
	localparam int rasterWidth = 9;
	// First raster number of a frame, count runs up to 511
	localparam logic [rasterWidth-1:0] rasterFirst = 9'd248;
	// Vertical blank starts on this line
	localparam logic [rasterWidth-1:0] rasterVblank = 9'd496;

	//======================================================================
	// Timer registers
	//======================================================================

	// Down-counter width
	localparam int timerWidth = 32;

	// CPU register index
	typedef enum logic [1:0] {
		regTimerHigh = 2'd0,
		regTimerLow  = 2'd1,
		regTimerCtrl = 2'd2,
		regIrqAck    = 2'd3
	} lspcReg;

	// Control word bits
	localparam int ctrlIrqEn          = 4;
	localparam int ctrlReloadOnWrite  = 5;
	localparam int ctrlReloadOnVblank = 6;
	localparam int ctrlReloadOnZero   = 7;
	localparam int ctrlStop           = 11;

endpackage

// File: common/timerCtrlIf.sv
//======================================================================
// Timer control bus
// Register values and one-cycle strobes from the register block
//======================================================================

`timescale 1ns/1ns

interface timerCtrlIf;
	import lspcPkg::*;

	// Full 32-bit reload value, high word first
	logic [timerWidth-1:0] reloadValue;
	// Pulses one cycle after the low word is written
	logic lowWritten;

	// Reload source selects
	logic reloadOnWrite;
	logic reloadOnVblank;
	logic reloadOnZero;

	// Interrupt enable and PAL stop option
	logic irqEn;
	logic stopEn;

	// Interrupt acknowledge, one cycle
	logic irqAck;

	// Register side drives everything
	modport regs (
		output reloadValue, lowWritten, reloadOnWrite, reloadOnVblank,
		output reloadOnZero, irqEn, stopEn, irqAck
	);

	// Timer side only listens
	modport timer (
		input reloadValue, lowWritten, reloadOnWrite, reloadOnVblank,
		input reloadOnZero, irqEn, stopEn, irqAck
	);

endinterface

// File: common/videoTimingIf.sv
//======================================================================
// Video line timing bus
// Raster line number with line start and frame start strobes
//======================================================================

`timescale 1ns/1ns

interface videoTimingIf;
	import lspcPkg::*;

	// Current raster line, 248 to 511
	logic [rasterWidth-1:0] rasterC;

	// First clock of every line
	// Changes together with rasterC
	logic lineStrobe;

	// First clock of the line where vertical blank begins
	logic frameStrobe;

	// Line counter end
	modport source (
		output rasterC, lineStrobe, frameStrobe
	);

	// Timer end
	modport sink (
		input rasterC, lineStrobe, frameStrobe
	);

endinterface

// File: rtl/lspcRegs.sv
//======================================================================
// LSPC timer register block
// Latches CPU writes into the reload halves and the control word
// and turns low word and acknowledge writes into one-cycle strobes
//======================================================================

`timescale 1ns/1ns

module lspcRegs (
	input  logic                 lspc6M,
	input  logic                 arstN,
	input  lspcPkg::lspcReg      cpuAddr,
	input  logic [15:0]          cpuData,
	input  logic                 cpuWr,
	timerCtrlIf.regs             ctrl
);
	import lspcPkg::*;

	// Reload value halves
	logic [15:0] timerHigh;
	logic [15:0] timerLow;
	// Control word, only a few bits are decoded
	logic [15:0] timerCtrl;

	// Registered write strobes
	logic lowWrQ;
	logic ackQ;

	//======================================================================
	// Register writes
	//======================================================================

	// One write per cycle, index picks the target
	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			timerHigh <= '0;
			timerLow  <= '0;
			timerCtrl <= '0;
		end else if (cpuWr) begin
			case (cpuAddr)
				regTimerHigh: timerHigh <= cpuData;
				regTimerLow:  timerLow  <= cpuData;
				regTimerCtrl: timerCtrl <= cpuData;
				// Ack has no storage
				default: ;
			endcase
		end
	end

	// Strobes are high for the cycle after the write edge
	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			lowWrQ <= 1'b0;
			ackQ   <= 1'b0;
		end else begin
			lowWrQ <= cpuWr && (cpuAddr == regTimerLow);
			ackQ   <= cpuWr && (cpuAddr == regIrqAck);
		end
	end

	//======================================================================
	// Outputs to the timer
	//======================================================================

	// High word on top
	assign ctrl.reloadValue = {timerHigh, timerLow};
	assign ctrl.lowWritten  = lowWrQ;
	assign ctrl.irqAck      = ackQ;

	// Control word fields
	assign ctrl.irqEn          = timerCtrl[ctrlIrqEn];
	assign ctrl.reloadOnWrite  = timerCtrl[ctrlReloadOnWrite];
	assign ctrl.reloadOnVblank = timerCtrl[ctrlReloadOnVblank];
	assign ctrl.reloadOnZero   = timerCtrl[ctrlReloadOnZero];
	// PAL stop option
	assign ctrl.stopEn         = timerCtrl[ctrlStop];

endmodule

// File: rtl/lspcTimerTop.sv
//======================================================================
// LSPC raster timer top level
// Connects the register block, the line counter and the timer
//======================================================================

`timescale 1ns/1ns

module lspcTimerTop (
	input  logic                             lspc6M,
	input  logic                             arstN,
	// CPU register port
	input  lspcPkg::lspcReg                  cpuAddr,
	input  logic [15:0]                      cpuData,
	input  logic                             cpuWr,
	// PAL when high
	input  logic                             vmode,
	output logic                             irq,
	output logic [lspcPkg::rasterWidth-1:0]  rasterC
);

	// Register block to timer
	timerCtrlIf ctrlBus ();
	// Line counter to timer
	videoTimingIf videoBus ();

	// CPU writes
	lspcRegs i_lspcRegs (
		.lspc6M  (lspc6M),
		.arstN   (arstN),
		.cpuAddr (cpuAddr),
		.cpuData (cpuData),
		.cpuWr   (cpuWr),
		.ctrl    (ctrlBus.regs)
	);

	// Raster line timing
	videoCounter i_videoCounter (
		.lspc6M (lspc6M),
		.arstN  (arstN),
		.video  (videoBus.source)
	);

	// Counter and interrupt
	rasterTimer i_rasterTimer (
		.lspc6M (lspc6M),
		.arstN  (arstN),
		.vmode  (vmode),
		.ctrl   (ctrlBus.timer),
		.video  (videoBus.sink),
		.irq    (irq)
	);

	// Raster number is also visible outside
	assign rasterC = videoBus.rasterC;

endmodule

// File: rtl/rasterTimer/rasterTimer.sv
//======================================================================
// LSPC raster timer
// 32-bit down-counter on the pixel clock with three reload sources,
// PAL blanking line stop and a latched interrupt output
//======================================================================

`timescale 1ns/1ns

module rasterTimer (
	input  logic       lspc6M,
	input  logic       arstN,
	// High selects PAL timing
	input  logic       vmode,
	timerCtrlIf.timer  ctrl,
	videoTimingIf.sink video,
	output logic       irq
);
	import lspcPkg::*;

	// The counter itself
	logic [timerWidth-1:0] count;

	// Low word write strobe delayed by one clock
	logic lowWrD;

	// Reload requests
	logic reloadWrite;
	logic reloadVblank;
	logic reloadZero;
	logic reloadNow;

	// Blanking line decode, held for the whole line
	logic blankLineQ;
	logic blankLine;
	// Registered pause for the stop option
	logic pauseQ;
	logic countEn;

	// Enabled clock with the counter at zero
	logic underflow;

	//======================================================================
	// Stop option
	//======================================================================

	// Blanking line when bit 8 is set or bits 5:4 are clear
	// Decoded on the first clock of each line while rasterC is new
	assign blankLine = video.lineStrobe
		? (video.rasterC[rasterWidth-1] | (video.rasterC[5:4] == 2'b00))
		: blankLineQ;

	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			blankLineQ <= 1'b0;
			pauseQ     <= 1'b0;
		end else begin
			blankLineQ <= blankLine;
			// Only PAL with the stop bit pauses
			pauseQ     <= ctrl.stopEn & vmode & blankLine;
		end
	end

	assign countEn = ~pauseQ;

	//======================================================================
	// Reload sources
	//======================================================================

	// Gives reloadValue after edge N+2 of the write
	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			lowWrD <= 1'b0;
		end else begin
			lowWrD <= ctrl.lowWritten;
		end
	end

	assign underflow    = countEn & (count == '0);

	assign reloadWrite  = lowWrD & ctrl.reloadOnWrite;
	// Loads on the edge that ends the frame strobe cycle
	assign reloadVblank = video.frameStrobe & ctrl.reloadOnVblank;
	// Periodic mode
	assign reloadZero   = underflow & ctrl.reloadOnZero;

	assign reloadNow = reloadWrite | reloadVblank | reloadZero;

	//======================================================================
	// Down-counter
	//======================================================================

	// Without a zero reload the count wraps to all ones
	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
		end else if (reloadNow) begin
			count <= ctrl.reloadValue;
		end else if (countEn) begin
			count <= count - 1'b1;
		end
	end

	//======================================================================
	// Interrupt latch
	//======================================================================

	// Set wins over an ack in the same cycle
	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			irq <= 1'b0;
		end else if (underflow & ctrl.irqEn) begin
			irq <= 1'b1;
		end else if (ctrl.irqAck) begin
			irq <= 1'b0;
		end
	end

endmodule

// File: rtl/videoCounter.sv
//======================================================================
// Video pixel and line counter
// Counts pixels within a line and raster lines within a frame,
// emits line start and vertical blank start strobes
//======================================================================

`timescale 1ns/1ns

module videoCounter (
	input  logic        lspc6M,
	input  logic        arstN,
	videoTimingIf.source video
);
	import lspcPkg::*;

	// Position within the current line
	logic [pixelWidth-1:0] pixelCnt;
	// Last pixel clock of the line
	logic lineEnd;
	// Raster number of the following line
	logic [rasterWidth-1:0] rasterNext;
	// Top of the raster range, 511
	logic [rasterWidth-1:0] rasterLast;

	assign rasterLast = rasterWidth'(rasterFirst + linesPerFrame - 1);
	assign lineEnd    = (pixelCnt == pixelWidth'(pixelsPerLine - 1));

	// Wraps back to the first line after 511
	assign rasterNext = (video.rasterC == rasterLast) ? rasterFirst
	                                                  : video.rasterC + 1'b1;

	//======================================================================
	// Pixel counter
	//======================================================================

	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			pixelCnt <= '0;
		end else if (lineEnd) begin
			pixelCnt <= '0;
		end else begin
			pixelCnt <= pixelCnt + 1'b1;
		end
	end

	//======================================================================
	// Line counter and strobes
	//======================================================================

	// rasterC and lineStrobe update on the same edge
	// so the strobe marks the first clock of the new line
	always_ff @(posedge lspc6M or negedge arstN) begin
		if (!arstN) begin
			video.rasterC     <= rasterFirst;
			video.lineStrobe  <= 1'b0;
			video.frameStrobe <= 1'b0;
		end else if (lineEnd) begin
			video.rasterC     <= rasterNext;
			video.lineStrobe  <= 1'b1;
			// Vertical blank begins with this line
			video.frameStrobe <= (rasterNext == rasterVblank);
		end else begin
			video.lineStrobe  <= 1'b0;
			video.frameStrobe <= 1'b0;
		end
	end

endmodule

// File: tests/tbLspcTimer.sv
//======================================================================
// LSPC raster timer testbench
// Drives CPU register writes and checks irq and rasterC against
// a cycle model of the timer
//======================================================================

`timescale 1ns/1ns

module tbLspcTimer;
	import lspcPkg::*;

	localparam int frameCycles = pixelsPerLine * linesPerFrame;
	localparam logic [15:0] bIrq    = 16'd1 << ctrlIrqEn;
	localparam logic [15:0] bWrite  = 16'd1 << ctrlReloadOnWrite;
	localparam logic [15:0] bVblank = 16'd1 << ctrlReloadOnVblank;
	localparam logic [15:0] bZero   = 16'd1 << ctrlReloadOnZero;
	localparam logic [15:0] bStop   = 16'd1 << ctrlStop;

	logic clk;
	logic arstN;
	lspcReg cpuAddr;
	logic [15:0] cpuData;
	logic cpuWr;
	logic vmode;
	logic irq;
	logic [rasterWidth-1:0] rasterC;

	int cyc;
	int errors;
	int testErr;
	int testsRun;
	int testsFailed;
	logic [31:0] seed;

	// Model state
	logic [timerWidth-1:0] mCount;
	logic mPause;
	logic mIrq;
	logic mWrD1;
	logic mWrD2;
	logic mAckD1;
	logic [15:0] mHigh;
	logic [15:0] mLow;
	logic [15:0] mCtrl;
	logic [rasterWidth-1:0] mPrevRaster;

	lspcTimerTop i_lspcTimerTop (
		.lspc6M  (clk),
		.arstN   (arstN),
		.cpuAddr (cpuAddr),
		.cpuData (cpuData),
		.cpuWr   (cpuWr),
		.vmode   (vmode),
		.irq     (irq),
		.rasterC (rasterC)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	//======================================================================
	// Reference model
	//======================================================================

	// One clock of the timer, fed with the write seen at this edge
	function automatic void stepModel(input logic wr, input lspcReg addr,
		input logic [15:0] data, input logic palMode,
		input logic [rasterWidth-1:0] rasterNow);
		logic under;
		logic frameStart;
		logic reload;
		under = !mPause && (mCount == '0);
		frameStart = (rasterNow == rasterVblank) && (mPrevRaster != rasterVblank);
		reload = (mWrD2 && mCtrl[ctrlReloadOnWrite]) ||
			(frameStart && mCtrl[ctrlReloadOnVblank]) ||
			(under && mCtrl[ctrlReloadOnZero]);
		if (reload)
			mCount = {mHigh, mLow};
		else if (!mPause)
			mCount = mCount - 32'd1;
		// An underflow beats a pending ack
		if (under && mCtrl[ctrlIrqEn])
			mIrq = 1'b1;
		else if (mAckD1)
			mIrq = 1'b0;
		mPause = mCtrl[ctrlStop] && palMode && (rasterNow[8] || rasterNow[5:4] == 2'b00);
		mWrD2 = mWrD1;
		mWrD1 = wr && (addr == regTimerLow);
		mAckD1 = wr && (addr == regIrqAck);
		if (wr && addr == regTimerHigh)
			mHigh = data;
		if (wr && addr == regTimerLow)
			mLow = data;
		if (wr && addr == regTimerCtrl)
			mCtrl = data;
		mPrevRaster = rasterNow;
	endfunction

	always @(posedge clk) begin
		if (!arstN) begin
			mCount = '0;
			mPause = 1'b0;
			mIrq = 1'b0;
			mWrD1 = 1'b0;
			mWrD2 = 1'b0;
			mAckD1 = 1'b0;
			mHigh = '0;
			mLow = '0;
			mCtrl = '0;
			mPrevRaster = rasterFirst;
		end else begin
			stepModel(cpuWr, cpuAddr, cpuData, vmode, rasterC);
		end
	end

	//======================================================================
	// Compare tasks and helpers
	//======================================================================

	task automatic checkIrq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED irq: got %h expected %h at cycle %0d", got, exp, cyc);
			errors++;
		end
	endtask

	task automatic checkRaster(input logic [rasterWidth-1:0] got,
		input logic [rasterWidth-1:0] exp);
		if (got !== exp) begin
			$display("FAILED rasterC: got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic checkCycles(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED %s: got %h expected %h", what, got, exp);
			errors++;
		end
	endtask

	// Compare every cycle in the middle of the clock period
	always @(negedge clk) begin
		if (arstN)
			checkIrq(irq, mIrq);
	end

	function automatic logic [15:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return 16'd16 + 16'(seed[23:16]);
	endfunction

	// Write is sampled on edge N, returns at the following falling edge
	task automatic writeReg(input lspcReg addr, input logic [15:0] data);
		@(posedge clk);
		cpuWr <= 1'b1;
		cpuAddr <= addr;
		cpuData <= data;
		@(posedge clk);
		cpuWr <= 1'b0;
		@(negedge clk);
	endtask

	task automatic waitIrq(input logic level, input int limit, output bit ok);
		int n;
		n = 0;
		ok = 1'b1;
		while (irq !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (irq !== level) begin
			$display("Timed out waiting for irq to become %0d", level);
			errors++;
			ok = 1'b0;
		end
	endtask

	// Waits until rasterC equals or differs from a value
	task automatic waitRaster(input logic [rasterWidth-1:0] value, input bit equal,
		input int limit, output bit ok);
		int n;
		n = 0;
		while (((rasterC == value) != equal) && n < limit) begin
			@(negedge clk);
			n++;
		end
		ok = ((rasterC == value) == equal);
		if (!ok) begin
			$display("Timed out waiting for rasterC near %h", value);
			errors++;
		end
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors == testErr) begin
			$display("Test %s passed", name);
		end else begin
			$display("Test %s failed with %0d errors", name, errors - testErr);
			testsFailed++;
		end
		testErr = errors;
	endtask

	//======================================================================
	// Tests
	//======================================================================

	initial begin
		logic [rasterWidth-1:0] prev;
		logic [rasterWidth-1:0] expR;
		logic [15:0] r;
		bit ok;
		int t0;
		int lastCyc;
		arstN = 1'b0;
		cpuAddr = regTimerHigh;
		cpuData = '0;
		cpuWr = 1'b0;
		vmode = 1'b0;
		cyc = 0;
		errors = 0;
		testErr = 0;
		testsRun = 0;
		testsFailed = 0;
		seed = 32'hc269_f8e7;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);

		// Line counter over one full frame and a bit
		checkIrq(irq, 1'b0);
		checkRaster(rasterC, rasterFirst);
		lastCyc = -1;
		for (int i = 0; i < linesPerFrame + 4; i++) begin
			prev = rasterC;
			expR = (prev == 9'd511) ? rasterFirst : prev + 9'd1;
			waitRaster(prev, 1'b0, pixelsPerLine + 4, ok);
			checkRaster(rasterC, expR);
			if (lastCyc >= 0)
				checkCycles("line length", cyc - lastCyc, pixelsPerLine);
			lastCyc = cyc;
		end
		endTest("line counting");

		// Single shot after a low word write
		writeReg(regTimerCtrl, bIrq | bWrite);
		writeReg(regTimerHigh, 16'h0000);
		r = nextRand();
		writeReg(regTimerLow, r);
		t0 = cyc;
		waitIrq(1'b1, r + 20, ok);
		if (ok)
			checkCycles("irq delay", cyc - t0, r + 3);
		writeReg(regIrqAck, 16'h0000);
		endTest("reload on write");

		// Periodic underflows with an ack after each
		writeReg(regTimerCtrl, bIrq | bWrite | bZero);
		r = nextRand();
		writeReg(regTimerLow, r);
		waitIrq(1'b1, r + 20, ok);
		t0 = cyc;
		for (int i = 0; i < 3; i++) begin
			writeReg(regIrqAck, 16'h0000);
			waitIrq(1'b0, 10, ok);
			waitIrq(1'b1, r + 10, ok);
			checkCycles("irq period", cyc - t0, r + 1);
			t0 = cyc;
		end
		endTest("periodic reload");

		// Underflows without irqEn
		writeReg(regTimerCtrl, bWrite | bZero);
		writeReg(regIrqAck, 16'h0000);
		waitIrq(1'b0, 10, ok);
		r = nextRand();
		writeReg(regTimerLow, r);
		repeat (3 * (r + 1)) @(negedge clk);
		writeReg(regIrqAck, 16'h0000);
		repeat (4) @(negedge clk);
		checkIrq(irq, 1'b0);
		endTest("interrupt enable");

		// Park the counter high, then restart it at vertical blank
		writeReg(regTimerCtrl, bIrq | bWrite);
		writeReg(regTimerHigh, 16'h0010);
		writeReg(regTimerLow, 16'h0000);
		writeReg(regTimerCtrl, bIrq | bVblank);
		writeReg(regTimerHigh, 16'h0000);
		r = nextRand();
		writeReg(regTimerLow, r);
		waitRaster(rasterVblank, 1'b0, pixelsPerLine + 4, ok);
		waitRaster(rasterVblank, 1'b1, frameCycles + 4, ok);
		t0 = cyc;
		waitIrq(1'b1, r + 20, ok);
		if (ok)
			checkCycles("vblank irq delay", cyc - t0, r + 2);
		endTest("reload at vblank");

		// Stop option, NTSC first and then PAL
		writeReg(regTimerCtrl, bIrq | bWrite | bStop);
		writeReg(regIrqAck, 16'h0000);
		waitIrq(1'b0, 10, ok);
		r = 16'd2000 + nextRand();
		writeReg(regTimerLow, r);
		t0 = cyc;
		waitIrq(1'b1, r + 20, ok);
		if (ok)
			checkCycles("NTSC irq delay", cyc - t0, r + 3);
		writeReg(regIrqAck, 16'h0000);
		@(posedge clk);
		vmode <= 1'b1;
		writeReg(regTimerLow, r);
		t0 = cyc;
		// The model follows the pauses cycle by cycle
		waitIrq(1'b1, 4 * frameCycles, ok);
		// Blanking lines hold the count back in PAL
		if (ok && cyc - t0 <= r + 3) begin
			$display("PAL irq was not delayed by the stop option");
			errors++;
		end
		writeReg(regIrqAck, 16'h0000);
		@(posedge clk);
		vmode <= 1'b0;
		repeat (4) @(negedge clk);
		endTest("stop option");

		$display("Tests run %0d, failed %0d, failed checks %0d",
			testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
